//--- hdl/n163_pkg.sv
// namco 163 mapper shared widths, address windows and cpu register decode
package n163_pkg;

	localparam int addr_w      = 16;
	localparam int chr_addr_w  = 14;
	localparam int bus_addr_w  = 22;
	localparam int prg_bank_w  = 6;
	localparam int chr_bank_w  = 8;
	localparam int irq_count_w = 16;

	localparam logic [bus_addr_w-14:0] wram_base = 9'b11_1100_000; // fixed 8k ram page
	localparam logic [3:0] chr_base  = 4'b1000;
	localparam logic [2:0] wram_page = 3'b011;  // 6000-7fff
	localparam logic [3:0] irq_page  = 4'b0101; // 5000-5fff

	// bank slots first so the value doubles as the chr_bank index
	typedef enum logic [4:0] {
		sel_chr0, sel_chr1, sel_chr2, sel_chr3,
		sel_chr4, sel_chr5, sel_chr6, sel_chr7,
		sel_nt0, sel_nt1, sel_nt2, sel_nt3,
		sel_prg89,
		sel_prgab_en,
		sel_prgcd,
		sel_irq_lo,
		sel_irq_hi,
		sel_none
	} reg_sel_t;

	function automatic reg_sel_t decode_reg_sel(input logic [addr_w-1:0] addr);
		reg_sel_t sel;
		if (addr[15] && addr[14:11] < 4'd12) begin
			sel = reg_sel_t'({1'b0, addr[14:11]}); // 8000-dfff
		end else begin
			case (addr[15:11])
				5'b11100: sel = sel_prg89;    // e000
				5'b11101: sel = sel_prgab_en; // e800
				5'b11110: sel = sel_prgcd;    // f000
				5'b01010: sel = sel_irq_lo;   // 5000
				5'b01011: sel = sel_irq_hi;   // 5800
				default:  sel = sel_none;     // f800 and unmapped pages
			endcase
		end
		return sel;
	endfunction

endpackage

//--- hdl/n163_bank_regs.sv
// namco 163 bank register file holding the chr, nametable and prg banks written by the cpu
`timescale 1ns/1ps

module n163_bank_regs import n163_pkg::*; (
	input  logic                  clk20,
	input  logic                  reset,
	input  logic                  ce,
	input  logic                  prg_write,
	input  logic [addr_w-1:0]     prg_ain,
	input  logic [7:0]            prg_din,
	output logic [chr_bank_w-1:0] chr_bank [12],
	output logic [1:0]            chr_ram_en,
	output logic [prg_bank_w-1:0] prg_bank_89,
	output logic [prg_bank_w-1:0] prg_bank_ab,
	output logic [prg_bank_w-1:0] prg_bank_cd
);

	reg_sel_t sel;

	assign sel = decode_reg_sel(prg_ain);

	always_ff @(posedge clk20) begin
		if (reset) begin
			chr_bank    <= '{default: '0};
			chr_ram_en  <= '0;
			prg_bank_89 <= '0;
			prg_bank_ab <= '0;
			prg_bank_cd <= '0;
		end else if (ce && prg_write) begin
			case (sel)
				sel_chr0, sel_chr1, sel_chr2, sel_chr3,
				sel_chr4, sel_chr5, sel_chr6, sel_chr7,
				sel_nt0, sel_nt1, sel_nt2, sel_nt3:
					chr_bank[sel[3:0]] <= prg_din;
				sel_prg89:
					prg_bank_89 <= prg_din[prg_bank_w-1:0]; // mirror bits dropped
				sel_prgab_en: begin
					chr_ram_en  <= prg_din[7:6];
					prg_bank_ab <= prg_din[prg_bank_w-1:0];
				end
				sel_prgcd:
					prg_bank_cd <= prg_din[prg_bank_w-1:0];
				default: ;
			endcase
		end
	end

	// a write to 8000-dfff lands in the slot named by address bits 14-11
	a_chr_write: assert property (@(posedge clk20) disable iff (reset)
		ce && prg_write && prg_ain[15] && prg_ain[14:13] != 2'b11
		|=> chr_bank[$past(prg_ain[14:11])] == $past(prg_din));

endmodule

//--- hdl/n163_irq_counter.sv
// namco 163 irq counter with a 15-bit up-count, overflow irq, cpu load and readback
`timescale 1ns/1ps

module n163_irq_counter import n163_pkg::*; (
	input  logic                   clk20,
	input  logic                   reset,
	input  logic                   ce,
	input  logic                   prg_write,
	input  logic [addr_w-1:0]      prg_ain,
	input  logic [7:0]             prg_din,
	output logic [irq_count_w-1:0] count,
	output logic                   irq
);

	reg_sel_t sel;
	logic in_win;
	logic count_up;
	logic [irq_count_w-1:0] count_next;

	assign sel        = decode_reg_sel(prg_ain);
	assign in_win     = (sel == sel_irq_lo) || (sel == sel_irq_hi); // 5000-5fff
	assign count_up   = count[15] & ~&count[14:0]; // runs while enabled, stops at 7fff
	assign count_next = count + 1'b1;

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= '0;
			irq   <= 1'b0;
		end else if (ce) begin
			if (in_win)
				irq <= 1'b0; // any access acks
			else if (&count)
				irq <= 1'b1;

			if (prg_write && sel == sel_irq_lo)
				count[7:0] <= prg_din;
			else if (count_up)
				count[7:0] <= count_next[7:0];

			if (prg_write && sel == sel_irq_hi)
				count[15:8] <= prg_din;
			else if (count_up)
				count[15:8] <= count_next[15:8];
		end
	end

	// irq only stays up while the counter sits stopped at ffff
	a_irq_count: assert property (@(posedge clk20) disable iff (reset)
		irq |-> count == '1);

endmodule

//--- hdl/n163_prg_map.sv
// namco 163 prg mapping, 8k bank select, work ram window and cpu read data
`timescale 1ns/1ps

module n163_prg_map import n163_pkg::*; #(
	parameter logic [prg_bank_w-1:0] PRG_MASK = '1
) (
	input  logic [addr_w-1:0]      prg_ain,
	input  logic                   prg_write,
	input  logic [7:0]             prg_din,
	input  logic [prg_bank_w-1:0]  prg_bank_89,
	input  logic [prg_bank_w-1:0]  prg_bank_ab,
	input  logic [prg_bank_w-1:0]  prg_bank_cd,
	input  logic [irq_count_w-1:0] count,
	output logic [bus_addr_w-1:0]  prg_aout,
	output logic                   prg_allow,
	output logic [7:0]             prg_dout,
	output logic                   prg_oe
);

	logic [prg_bank_w-1:0] bank_sel;
	logic [prg_bank_w-1:0] bank_m;
	logic is_wram;
	logic is_irq;

	always_comb begin
		case (prg_ain[14:13])
			2'd0: bank_sel = prg_bank_89;
			2'd1: bank_sel = prg_bank_ab;
			2'd2: bank_sel = prg_bank_cd;
			default: bank_sel = '1; // e000-ffff fixed to last bank
		endcase
	end

	// low two bank bits forced off below 8000
	assign bank_m  = bank_sel & PRG_MASK & {{(prg_bank_w-2){1'b1}}, {2{prg_ain[15]}}};
	assign is_wram = prg_ain[15:13] == wram_page;
	assign is_irq  = prg_ain[15:12] == irq_page;

	always_comb begin
		if (is_wram)
			prg_aout = {wram_base, prg_ain[12:0]};
		else
			prg_aout = {{(bus_addr_w-13-prg_bank_w){1'b0}}, bank_m, prg_ain[12:0]};
	end

	assign prg_allow = (prg_ain[15] & ~prg_write) | is_wram;
	assign prg_oe    = ~prg_write & (is_wram | prg_ain[15] | is_irq);

	always_comb begin
		if (is_irq)
			prg_dout = prg_ain[11] ? count[15:8] : count[7:0]; // 5800 hi, 5000 lo
		else
			prg_dout = prg_din;
	end

endmodule

//--- hdl/n163_chr_map.sv
// namco 163 chr mapping, 1k bank select, chr ram and nametable vram routing
`timescale 1ns/1ps

module n163_chr_map import n163_pkg::*; #(
	parameter logic [5:0] CHR_MASK = '1
) (
	input  logic [chr_addr_w-1:0] chr_ain,
	input  logic                  chr_write,
	input  logic [chr_bank_w-1:0] chr_bank [12],
	input  logic [1:0]            chr_ram_en,
	output logic [bus_addr_w-1:0] chr_aout,
	output logic                  chr_ram_we,
	output logic                  vram_ce,
	output logic                  vram_a10
);

	logic [3:0] bank_idx;
	logic [chr_bank_w-1:0] bank;
	logic bank_high;
	logic bank_ram;

	// 0000-1fff pattern slots 0-7, 2000-3fff nametable slots 8-11 repeating
	always_comb begin
		if (chr_ain[13])
			bank_idx = {2'b10, chr_ain[11:10]};
		else
			bank_idx = {1'b0, chr_ain[12:10]};
	end

	assign bank = chr_bank[bank_idx];

	// e0-ff banks point at internal vram
	assign bank_high = &bank[7:5];
	assign bank_ram  = bank_high & ~chr_ram_en[chr_ain[12]]; // enable per 4k half

	always_comb begin
		if (!chr_ain[13]) begin
			vram_ce    = bank_ram;
			chr_ram_we = chr_write & bank_ram;
		end else begin
			vram_ce    = bank_high;
			chr_ram_we = chr_write & bank_ram & ~bank_high;
		end
	end

	always_comb begin
		chr_aout[21:19] = chr_base[3:1];
		chr_aout[18]    = vram_ce; // marks the vram page
		chr_aout[17:12] = bank[7:2] & CHR_MASK;
		chr_aout[11:10] = bank[1:0];
		chr_aout[9:0]   = chr_ain[9:0];
	end

	assign vram_a10 = chr_aout[10];

endmodule

//--- hdl/n163_mapper.sv
// namco 163 mapper top, register file, irq counter and prg/chr address mapping
`timescale 1ns/1ps

module n163_mapper import n163_pkg::*; #(
	parameter logic [prg_bank_w-1:0] PRG_MASK = '1,
	parameter logic [5:0]            CHR_MASK = '1
) (
	input  logic                  clk20,
	input  logic                  reset,
	input  logic                  ce,         // one strobe per cpu cycle
	input  logic [addr_w-1:0]     prg_ain,
	input  logic                  prg_write,
	input  logic [7:0]            prg_din,
	input  logic [chr_addr_w-1:0] chr_ain,
	input  logic                  chr_write,
	output logic [bus_addr_w-1:0] prg_aout,
	output logic                  prg_allow,
	output logic [7:0]            prg_dout,
	output logic                  prg_oe,
	output logic [bus_addr_w-1:0] chr_aout,
	output logic                  chr_ram_we,
	output logic                  vram_ce,
	output logic                  vram_a10,
	output logic                  irq
);

	logic [chr_bank_w-1:0]  chr_bank [12];
	logic [1:0]             chr_ram_en;
	logic [prg_bank_w-1:0]  prg_bank_89;
	logic [prg_bank_w-1:0]  prg_bank_ab;
	logic [prg_bank_w-1:0]  prg_bank_cd;
	logic [irq_count_w-1:0] count;

	n163_bank_regs u_bank_regs (
		.clk20(clk20), .reset(reset), .ce(ce),
		.prg_write(prg_write), .prg_ain(prg_ain), .prg_din(prg_din),
		.chr_bank(chr_bank), .chr_ram_en(chr_ram_en),
		.prg_bank_89(prg_bank_89), .prg_bank_ab(prg_bank_ab), .prg_bank_cd(prg_bank_cd)
	);

	n163_irq_counter u_irq_counter (
		.clk20(clk20), .reset(reset), .ce(ce),
		.prg_write(prg_write), .prg_ain(prg_ain), .prg_din(prg_din),
		.count(count), .irq(irq)
	);

	n163_prg_map #(.PRG_MASK(PRG_MASK)) u_prg_map (
		.prg_ain(prg_ain), .prg_write(prg_write), .prg_din(prg_din),
		.prg_bank_89(prg_bank_89), .prg_bank_ab(prg_bank_ab), .prg_bank_cd(prg_bank_cd),
		.count(count),
		.prg_aout(prg_aout), .prg_allow(prg_allow), .prg_dout(prg_dout), .prg_oe(prg_oe)
	);

	n163_chr_map #(.CHR_MASK(CHR_MASK)) u_chr_map (
		.chr_ain(chr_ain), .chr_write(chr_write),
		.chr_bank(chr_bank), .chr_ram_en(chr_ram_en),
		.chr_aout(chr_aout), .chr_ram_we(chr_ram_we), .vram_ce(vram_ce), .vram_a10(vram_a10)
	);

endmodule

//--- bench/n163_checker.sv
// n163 output checker that compares every dut output with the bench model each cycle
`timescale 1ns/1ps

module n163_checker import n163_pkg::*; (
	input  logic                  clk20,
	input  logic                  reset,
	input  logic                  check_en,
	input  logic                  test_end,
	input  int                    test_id,
	input  logic [bus_addr_w-1:0] prg_aout, exp_prg_aout,
	input  logic                  prg_allow, exp_prg_allow,
	input  logic [7:0]            prg_dout, exp_prg_dout,
	input  logic                  prg_oe, exp_prg_oe,
	input  logic [bus_addr_w-1:0] chr_aout, exp_chr_aout,
	input  logic                  chr_ram_we, exp_chr_ram_we,
	input  logic                  vram_ce, exp_vram_ce,
	input  logic                  vram_a10, exp_vram_a10,
	input  logic                  irq, exp_irq,
	output int                    errors,
	output int                    tests_ok,
	output int                    tests_bad
);

	int err_cnt = 0;
	int test_errs = 0;
	int ok_cnt = 0;
	int bad_cnt = 0;

	assign errors    = err_cnt;
	assign tests_ok  = ok_cnt;
	assign tests_bad = bad_cnt;

	function automatic string test_name(input int id);
		case (id)
			1: return "reset state";
			2: return "prg banks";
			3: return "chr banks";
			4: return "counter readback";
			5: return "irq rise";
			6: return "irq ack";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("Fail %s expected %h got %h at %0t", name, exp, got, $time);
			err_cnt++;
			test_errs++;
		end
	endtask

	// sampled mid-cycle once the outputs settle
	always @(negedge clk20) begin
		if (check_en && !reset) begin
			compare("prg_aout", 32'(exp_prg_aout), 32'(prg_aout));
			compare("prg_allow", 32'(exp_prg_allow), 32'(prg_allow));
			compare("prg_dout", 32'(exp_prg_dout), 32'(prg_dout));
			compare("prg_oe", 32'(exp_prg_oe), 32'(prg_oe));
			compare("chr_aout", 32'(exp_chr_aout), 32'(chr_aout));
			compare("chr_ram_we", 32'(exp_chr_ram_we), 32'(chr_ram_we));
			compare("vram_ce", 32'(exp_vram_ce), 32'(vram_ce));
			compare("vram_a10", 32'(exp_vram_a10), 32'(vram_a10));
			compare("irq", 32'(exp_irq), 32'(irq));
		end
		if (test_end) begin
			if (test_errs == 0) begin
				$display("test %0d %s passed", test_id, test_name(test_id));
				ok_cnt++;
			end else begin
				$display("test %0d %s failed, %0d mismatches", test_id, test_name(test_id),
					test_errs);
				bad_cnt++;
			end
			test_errs = 0;
		end
	end

endmodule

//--- bench/n163_tb.sv
// n163 mapper testbench driving random cpu and ppu bus traffic against a cycle model
`timescale 1ns/1ps

module n163_tb import n163_pkg::*; ();

	logic clk20;
	logic reset;
	logic ce;
	logic prg_write;
	logic [addr_w-1:0] prg_ain;
	logic [7:0] prg_din;
	logic [chr_addr_w-1:0] chr_ain;
	logic chr_write;
	logic [bus_addr_w-1:0] prg_aout, chr_aout;
	logic prg_allow, prg_oe, chr_ram_we, vram_ce, vram_a10, irq;
	logic [7:0] prg_dout;

	// model state
	logic [7:0] m_chr [12];
	logic [1:0] m_ram_en;
	logic [5:0] m_p89, m_pab, m_pcd;
	logic [15:0] m_count, m_count_nxt;
	logic m_irq;

	logic [bus_addr_w-1:0] exp_prg_aout, exp_chr_aout;
	logic exp_prg_allow, exp_prg_oe, exp_chr_ram_we, exp_vram_ce, exp_vram_a10, exp_irq;
	logic [7:0] exp_prg_dout;

	logic [4:0] slot;
	logic in_win;
	logic is_wram;
	logic [5:0] pbank;
	logic [3:0] cidx;
	logic [7:0] cbank;
	logic c_high;
	logic c_ram;

	int seed;
	logic check_en;
	logic test_end;
	int test_id, errors, tests_ok, tests_bad, timeouts;

	n163_mapper n163_mapper_inst (.*);
	n163_checker checker_inst (.*);

	initial begin
		clk20 = 1'b0;
		forever #5 clk20 = ~clk20;
	end

	assign slot    = prg_ain[15:11];         // 2k register slots
	assign in_win  = prg_ain[15:12] == 4'h5;
	assign is_wram = prg_ain[15:13] == 3'b011;

	always_comb begin
		m_count_nxt = m_count;
		if (m_count[15] && m_count[14:0] != 15'h7fff)
			m_count_nxt = m_count + 16'd1;
		if (prg_write && slot == 5'd10)
			m_count_nxt[7:0] = prg_din;   // 5000
		if (prg_write && slot == 5'd11)
			m_count_nxt[15:8] = prg_din;  // 5800
	end

	always @(posedge clk20) begin
		if (reset) begin
			m_chr    <= '{default: 8'h00};
			m_ram_en <= 2'b00;
			m_p89    <= 6'd0;
			m_pab    <= 6'd0;
			m_pcd    <= 6'd0;
			m_count  <= 16'h0000;
			m_irq    <= 1'b0;
		end else if (ce) begin
			if (prg_write && slot >= 5'd16 && slot <= 5'd27)
				m_chr[slot[3:0]] <= prg_din;
			if (prg_write && slot == 5'd28)
				m_p89 <= prg_din[5:0];
			if (prg_write && slot == 5'd29) begin
				m_pab    <= prg_din[5:0];
				m_ram_en <= prg_din[7:6];
			end
			if (prg_write && slot == 5'd30)
				m_pcd <= prg_din[5:0];
			m_count <= m_count_nxt;
			if (in_win)
				m_irq <= 1'b0;
			else if (m_count == 16'hffff)
				m_irq <= 1'b1;
		end
	end

	// default masks are all ones
	always_comb begin
		case (prg_ain[14:13])
			2'd0: pbank = m_p89;
			2'd1: pbank = m_pab;
			2'd2: pbank = m_pcd;
			default: pbank = 6'h3f;
		endcase
		if (!prg_ain[15])
			pbank[1:0] = 2'b00;
		exp_prg_aout  = is_wram ? {wram_base, prg_ain[12:0]} : {3'b000, pbank, prg_ain[12:0]};
		exp_prg_allow = (prg_ain[15] && !prg_write) || is_wram;
		exp_prg_oe    = !prg_write && (is_wram || prg_ain[15] || in_win);
		if (!in_win)
			exp_prg_dout = prg_din;
		else
			exp_prg_dout = prg_ain[11] ? m_count[15:8] : m_count[7:0];
		exp_irq = m_irq;
	end

	always_comb begin
		cidx   = chr_ain[13] ? {2'b10, chr_ain[11:10]} : {1'b0, chr_ain[12:10]};
		cbank  = m_chr[cidx];
		c_high = cbank[7:5] == 3'b111;
		c_ram  = c_high && !m_ram_en[chr_ain[12]];
		if (!chr_ain[13]) begin
			exp_vram_ce    = c_ram;
			exp_chr_ram_we = chr_write && c_ram;
		end else begin
			exp_vram_ce    = c_high;
			exp_chr_ram_we = chr_write && c_ram && !exp_vram_ce;
		end
		exp_chr_aout = {chr_base[3:1], exp_vram_ce, cbank, chr_ain[9:0]};
		exp_vram_a10 = exp_chr_aout[10];
	end

	function automatic logic [15:0] rnd16();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic logic [15:0] outside_win();
		logic [15:0] a;
		a = rnd16();
		if (a[15:12] == 4'h5)
			a[15] = 1'b1;
		return a;
	endfunction

	task automatic bus_cycle(
		input logic c,
		input logic w,
		input logic [15:0] a,
		input logic [7:0] d
	);
		logic [15:0] r;
		r = rnd16();
		@(posedge clk20);
		ce        <= c;
		prg_write <= w;
		prg_ain   <= a;
		prg_din   <= d;
		chr_ain   <= r[13:0];  // ppu side runs random all the time
		chr_write <= r[15];
	endtask

	task automatic end_test();
		@(posedge clk20);
		test_end <= 1'b1;
		ce       <= 1'b0;
		@(posedge clk20);
		test_end <= 1'b0;
	endtask

	task automatic wait_irq(input int limit);
		logic [15:0] r;
		int n;
		n = 0;
		@(negedge clk20);
		while (!irq && n < limit) begin
			r = rnd16();
			bus_cycle(r[0], 1'b0, outside_win(), r[15:8]);
			@(negedge clk20);
			n++;
		end
		if (!irq) begin
			$display("timeout, irq did not rise within %0d cycles", limit);
			timeouts++;
		end
	endtask

	task automatic test_reset_state();
		logic [15:0] a;
		logic [15:0] r;
		test_id <= 1;
		repeat (16) begin
			r = rnd16();
			a = rnd16();
			a[15] = 1'b1;
			if (a[14:13] == 2'b11)
				a[13] = 1'b0; // stay below e000
			bus_cycle(r[0], 1'b0, a, r[15:8]);
		end
		end_test();
	endtask

	task automatic test_prg_banks();
		logic [15:0] a;
		logic [15:0] r;
		test_id <= 2;
		repeat (48) begin
			r = rnd16();
			a = rnd16();
			a[15:11] = (r[1:0] == 2'd0) ? 5'd28 : (r[1:0] == 2'd1) ? 5'd29 : 5'd30;
			bus_cycle(1'b1, 1'b1, a, r[15:8]);
			repeat (4) begin
				r = rnd16();
				bus_cycle(r[0], r[1], rnd16(), r[15:8]);
			end
		end
		end_test();
	endtask

	task automatic test_chr_banks();
		logic [15:0] a;
		logic [15:0] r;
		test_id <= 3;
		repeat (64) begin
			r = rnd16();
			a = rnd16();
			a[15:11] = (r[3:0] > 4'd11) ? 5'd29 : {1'b1, r[3:0]};
			// lean toward e0-ff banks
			bus_cycle(1'b1, 1'b1, a, r[4] ? (r[15:8] | 8'he0) : r[15:8]);
			repeat (4)
				bus_cycle(1'b0, 1'b0, rnd16(), 8'h00);
		end
		end_test();
	endtask

	task automatic test_count_readback();
		logic [15:0] r;
		test_id <= 4;
		repeat (16) begin
			r = rnd16();
			bus_cycle(1'b1, 1'b1, {5'b01010, r[10:0]}, r[15:8]);
			r = rnd16();
			bus_cycle(1'b1, 1'b1, {5'b01011, r[10:0]}, r[15:8]);
			bus_cycle(1'b1, 1'b0, 16'h5000, 8'h00);
			bus_cycle(1'b1, 1'b0, 16'h5800, 8'h00);
			repeat (6) begin
				r = rnd16();
				bus_cycle(r[0], 1'b0, outside_win(), 8'h00);
			end
			bus_cycle(1'b0, 1'b0, 16'h5000, 8'h00);
			bus_cycle(1'b0, 1'b0, 16'h5800, 8'h00);
		end
		end_test();
	endtask

	task automatic test_irq_rise();
		test_id <= 5;
		bus_cycle(1'b1, 1'b1, 16'h5800, 8'h00); // halt counting first
		bus_cycle(1'b1, 1'b1, 16'h5000, 8'hf0);
		bus_cycle(1'b1, 1'b1, 16'h5800, 8'hff);
		wait_irq(100);
		repeat (8)
			bus_cycle(1'b1, 1'b0, outside_win(), 8'h00);
		bus_cycle(1'b0, 1'b0, 16'h5000, 8'h00);
		bus_cycle(1'b0, 1'b0, 16'h5800, 8'h00);
		end_test();
	endtask

	task automatic test_irq_ack();
		logic [15:0] r;
		test_id <= 6;
		repeat (8) begin
			bus_cycle(1'b1, 1'b1, 16'h5800, 8'hff);
			bus_cycle(1'b1, 1'b1, 16'h5000, 8'hff);
			wait_irq(20);
			r = rnd16();
			bus_cycle(1'b1, r[12], {4'h5, r[11:0]}, r[15:8]);
			bus_cycle(1'b0, 1'b0, outside_win(), 8'h00);
		end
		end_test();
	endtask

	initial begin
		seed      = 28;
		reset     = 1'b1;
		ce        = 1'b0;
		prg_write = 1'b0;
		prg_ain   = '0;
		prg_din   = 8'h00;
		chr_ain   = '0;
		chr_write = 1'b0;
		check_en  = 1'b0;
		test_end  = 1'b0;
		test_id   = 0;
		timeouts  = 0;
		repeat (4) @(posedge clk20);
		reset    <= 1'b0;
		check_en <= 1'b1;
		test_reset_state();
		test_prg_banks();
		test_chr_banks();
		test_count_readback();
		test_irq_rise();
		test_irq_ack();
		@(negedge clk20);
		$display("%0d tests passed, %0d failed, %0d mismatches, %0d timeouts",
			tests_ok, tests_bad, errors, timeouts);
		if (errors == 0 && tests_bad == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- n163_mapper.f
hdl/n163_pkg.sv
hdl/n163_bank_regs.sv
hdl/n163_irq_counter.sv
hdl/n163_prg_map.sv
hdl/n163_chr_map.sv
hdl/n163_mapper.sv
bench/n163_checker.sv
bench/n163_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module n163_tb -f n163_mapper.f -o n163_sim

out=$(./obj_dir/n163_sim)
echo "$out"
if echo "$out" | grep -q "^Simulation PASSED$"; then
	exit 0
fi
exit 1
